// ==== l1_cache.f ====
cache_cfg_pkg.sv
bus_pkg.sv
cache_array.sv
addr_decode.sv
cache_ctrl.sv
proc_response.sv
l1_cache.sv
tb_mem_model.sv
l1_cache_assertions.sv
tb_l1_cache.sv

// ==== tb_l1_cache.sv ====
`timescale 1ns/1ps

module tb_l1_cache
    import cache_cfg_pkg::*, bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;   // ~60 requests at ~20 cycles, flush, margin

    logic      CLK = 1'b0;
    logic      nRST;
    logic      flush;
    logic      flush_done;
    proc_req_t proc_req;
    proc_rsp_t proc_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;
    int        cycles = 0;

    always #5 CLK = ~CLK;

    l1_cache u_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_mem_model u_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (mem_req),
        .rsp  (mem_rsp)
    );

    bind l1_cache l1_cache_assertions u_chk (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    // one processor request, held until busy is seen low at an edge
    task automatic proc_access(input logic is_write, input word_t addr, input word_t wdata,
                               input logic [3:0] be);
        @(negedge CLK);
        proc_req.ren     = !is_write;
        proc_req.wen     = is_write;
        proc_req.addr    = addr;
        proc_req.wdata   = wdata;
        proc_req.byte_en = be;
        do begin
            @(posedge CLK);
        end while (proc_rsp.busy);
        @(negedge CLK);
        proc_req = '0;
    endtask

    task automatic run_flush();
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        do begin
            @(posedge CLK);
        end while (!flush_done);
    endtask

    function automatic word_t loop_addr(input int i);
        return word_t'(((i * 52) % 1024) * 4);  // spread over sets and tags
    endfunction

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        repeat (8) @(negedge CLK);
        nRST = 1'b1;
        repeat (20) @(negedge CLK);     // let the sweep run with the bus idle

        proc_access(1'b0, 32'h0000_0100, '0, 4'h0);    // miss
        proc_access(1'b0, 32'h0000_0104, '0, 4'h0);    // same block, hit
        proc_access(1'b1, 32'h0000_0104, 32'haabb_ccdd, 4'b0010);
        proc_access(1'b1, 32'h0000_0104, 32'h1122_3344, 4'b1100);
        proc_access(1'b0, 32'h0000_0104, '0, 4'h0);
        proc_access(1'b1, 32'h0000_0100, 32'h5566_7788, 4'b0011);
        proc_access(1'b0, 32'h0000_0180, '0, 4'h0);    // same set, dirty victim
        proc_access(1'b0, 32'h0000_0100, '0, 4'h0);

        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 1) begin
                proc_access(1'b1, loop_addr(i), {8'(i), 8'hc3, 8'(i * 3), 8'h5a},
                            (i % 5 == 1) ? 4'hf : 4'(1 << (i % 4)));
            end
            proc_access(1'b0, loop_addr(i), '0, 4'h0);
        end

        run_flush();
        proc_access(1'b0, 32'h0000_0100, '0, 4'h0);
        proc_access(1'b0, 32'h0000_0104, '0, 4'h0);
        for (int i = 1; i < 20; i += 2) begin
            proc_access(1'b0, loop_addr(i), '0, 4'h0);
        end

        repeat (2) @(negedge CLK);
        $display("errors: %0d", u_dut.u_chk.err_cnt);
        if (u_dut.u_chk.err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== l1_cache_assertions.sv ====
`timescale 1ns/1ps

// bound into l1_cache, shadow of every completed processor write
module l1_cache_assertions import cache_cfg_pkg::*, bus_pkg::*; (
    input logic      CLK,
    input logic      nRST,
    input logic      flush_done,
    input proc_req_t proc_req,
    input proc_rsp_t proc_rsp,
    input mem_req_t  mem_req,
    input mem_rsp_t  mem_rsp
);

    localparam int MEM_WORDS = 1024;

    word_t                     shadow [MEM_WORDS];
    int                        err_cnt = 0;
    logic                      proc_done;
    logic                      mem_done;
    logic [9:0]                req_widx;
    logic [9:0]                mem_widx;
    logic [SET_W-1:0]          req_set;
    logic                      req_seen;
    logic                      wb_next;     // rest of a write-back block still owed
    word_t                     wb_addr;
    logic                      last_valid;
    logic [WORD_W-OFS_W-3:0]   last_blk;
    logic                      rd_since;    // memory read since the last request
    logic [N_SETS-1:0]         set_flushed; // set not accessed since the last flush

    function automatic word_t init_pattern(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6a09_e667;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = init_pattern(word_t'(i) << 2);
        end
    end

    assign proc_done = (proc_req.ren || proc_req.wen) && !proc_rsp.busy;
    assign mem_done  = (mem_req.ren || mem_req.wen) && !mem_rsp.busy;
    assign req_widx  = proc_req.addr[11:2];
    assign mem_widx  = mem_req.addr[11:2];
    assign req_set   = proc_req.addr[OFS_W+2 +: SET_W];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_seen    <= 1'b0;
            wb_next     <= 1'b0;
            wb_addr     <= '0;
            last_valid  <= 1'b0;
            last_blk    <= '0;
            rd_since    <= 1'b0;
            set_flushed <= '0;
        end else begin
            if (proc_req.ren || proc_req.wen) begin
                req_seen <= 1'b1;
            end
            if (mem_done) begin
                wb_next <= mem_req.wen && (mem_req.addr[2 +: OFS_W] != OFS_W'(BLOCK_WORDS - 1));
                wb_addr <= mem_req.addr + 32'd4;
                rd_since <= rd_since || mem_req.ren;
            end
            if (flush_done) begin
                set_flushed <= '1;      // every set must miss once
            end
            if (proc_done) begin
                last_valid           <= 1'b1;
                last_blk             <= proc_req.addr[WORD_W-1:OFS_W+2];
                rd_since             <= 1'b0;
                set_flushed[req_set] <= 1'b0;
            end
            if (flush_done) begin
                last_valid <= 1'b0;     // every line is gone after a flush
            end
        end
    end

    // byte lane merge into the shadow
    always @(posedge CLK) begin
        if (nRST && proc_done && proc_req.wen) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (proc_req.byte_en[b]) begin
                    shadow[req_widx][8*b +: 8] <= proc_req.wdata[8*b +: 8];
                end
            end
        end
    end

    a_sweep_idle: assert property (@(posedge CLK) disable iff (!nRST)
        !req_seen && !(proc_req.ren || proc_req.wen)
            |-> !mem_req.ren && !mem_req.wen && !flush_done)
        else begin
            err_cnt++;
            $error("memory bus or flush_done went active before any request");
        end

    a_rdata: assert property (@(posedge CLK) disable iff (!nRST)
        proc_done && proc_req.ren |-> proc_rsp.rdata == shadow[req_widx])
        else begin
            err_cnt++;
            $error("FAILED %0t read of %h returned %h, expected %h", $time,
                   $sampled(proc_req.addr), $sampled(proc_rsp.rdata),
                   $sampled(shadow[req_widx]));
        end

    a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
        mem_done && mem_req.wen |-> mem_req.wdata == shadow[mem_widx])
        else begin
            err_cnt++;
            $error("FAILED %0t memory write to %h carried %h, expected %h", $time,
                   $sampled(mem_req.addr), $sampled(mem_req.wdata),
                   $sampled(shadow[mem_widx]));
        end

    a_wb_start: assert property (@(posedge CLK) disable iff (!nRST)
        mem_done && mem_req.wen && !wb_next |-> mem_req.addr[2 +: OFS_W] == '0)
        else begin
            err_cnt++;
            $error("a write-back block did not start at its first word");
        end

    a_wb_order: assert property (@(posedge CLK) disable iff (!nRST)
        mem_done && wb_next |-> mem_req.wen && mem_req.addr == wb_addr)
        else begin
            err_cnt++;
            $error("FAILED %0t write-back expected a write to %h", $time, $sampled(wb_addr));
        end

    a_no_refetch: assert property (@(posedge CLK) disable iff (!nRST)
        proc_done && last_valid && proc_req.addr[WORD_W-1:OFS_W+2] == last_blk |-> !rd_since)
        else begin
            err_cnt++;
            $error("memory was read again for a block that was already cached");
        end

    a_flush_miss: assert property (@(posedge CLK) disable iff (!nRST)
        proc_done && set_flushed[req_set] |-> rd_since)
        else begin
            err_cnt++;
            $error("first access to a set after a flush was served without a memory read");
        end

    a_flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            err_cnt++;
            $error("flush_done stayed high for more than one cycle");
        end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

// word memory behind the cache, 4 KB window from address zero
module tb_mem_model import cache_cfg_pkg::*, bus_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] SEED      = 32'h5bfe_93be;

    word_t       mem [MEM_WORDS];
    logic [31:0] rng_state;
    logic [31:0] rng_next;
    logic [1:0]  wait_left;     // busy cycles left for the current transfer

    function automatic word_t init_pattern(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6a09_e667;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_pattern(word_t'(i) << 2);
        end
    end

    assign rng_next  = lcg_next(rng_state);
    assign rsp.busy  = (wait_left != 2'd0);
    assign rsp.rdata = mem[req.addr[11:2]];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rng_state <= SEED;
            wait_left <= 2'd0;
        end else if (req.ren || req.wen) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin      // transfer done, draw the wait for the next one
                rng_state <= rng_next;
                wait_left <= rng_next[31:30];
            end
        end
    end

    always @(posedge CLK) begin
        if (nRST && req.wen && wait_left == 2'd0) begin
            mem[req.addr[11:2]] <= req.wdata;
        end
    end

endmodule

// ==== l1_cache.sv ====
`timescale 1ns/1ps

module l1_cache import cache_cfg_pkg::*, bus_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      flush,
    output logic      flush_done,
    input  proc_req_t proc_req,
    output proc_rsp_t proc_rsp,
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp
);

    lookup_t          lookup;
    line_tag_t        tag_rd;
    line_tag_t        tag_wr;
    line_data_t       data_rd;
    line_data_t       data_wr;
    line_data_t       merged;
    logic             tag_wen;
    logic             data_wen;
    logic             in_lookup;
    logic [SET_W-1:0] set_idx;

    // tag and data arrays share the set index
    cache_array #(.DEPTH(N_SETS), .entry_t(line_tag_t)) u_tags (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (tag_wen),
        .idx   (set_idx),
        .wdata (tag_wr),
        .rdata (tag_rd)
    );

    cache_array #(.DEPTH(N_SETS), .entry_t(line_data_t)) u_data (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (data_wen),
        .idx   (set_idx),
        .wdata (data_wr),
        .rdata (data_rd)
    );

    addr_decode u_decode (
        .req    (proc_req),
        .tag_rd (tag_rd),
        .lookup (lookup)
    );

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .req        (proc_req),
        .lookup     (lookup),
        .tag_rd     (tag_rd),
        .data_rd    (data_rd),
        .merged     (merged),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .tag_wen    (tag_wen),
        .data_wen   (data_wen),
        .set_idx    (set_idx),
        .tag_wr     (tag_wr),
        .data_wr    (data_wr),
        .in_lookup  (in_lookup)
    );

    proc_response u_resp (
        .req       (proc_req),
        .lookup    (lookup),
        .in_lookup (in_lookup),
        .data_rd   (data_rd),
        .rsp       (proc_rsp),
        .merged    (merged)
    );

endmodule

// ==== proc_response.sv ====
`timescale 1ns/1ps

module proc_response import cache_cfg_pkg::*, bus_pkg::*; (
    input  proc_req_t  req,
    input  lookup_t    lookup,
    input  logic       in_lookup,
    input  line_data_t data_rd,
    output proc_rsp_t  rsp,
    output line_data_t merged
);

    word_t cur_word;
    word_t new_word;

    // addressed word of the current line
    assign cur_word = data_rd[lookup.addr.ofs];

    // byte lane merge, untouched lanes keep the cached value
    always_comb begin
        new_word = cur_word;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (req.byte_en[b]) begin
                new_word[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        merged                   = data_rd;
        merged[lookup.addr.ofs]  = new_word;
    end

    // request completes only on a hit seen in lookup
    assign rsp.busy  = !(in_lookup && lookup.hit && (req.ren || req.wen));
    assign rsp.rdata = cur_word;

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_cfg_pkg::*, bus_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             flush,
    output logic             flush_done,
    input  proc_req_t        req,
    input  lookup_t          lookup,
    input  line_tag_t        tag_rd,
    input  line_data_t       data_rd,
    input  line_data_t       merged,
    output mem_req_t         mem_req,
    input  mem_rsp_t         mem_rsp,
    output logic             tag_wen,
    output logic             data_wen,
    output logic [SET_W-1:0] set_idx,
    output line_tag_t        tag_wr,
    output line_data_t       data_wr,
    output logic             in_lookup
);

    typedef enum logic [2:0] {SWEEP, LOOKUP, WRITE_BACK, FETCH, FLUSH} state_t;

    localparam logic [OFS_W-1:0] LAST_WORD = OFS_W'(BLOCK_WORDS - 1);
    localparam logic [SET_W-1:0] LAST_SET  = SET_W'(N_SETS - 1);

    state_t           state, next_state;
    logic [OFS_W-1:0] word_cnt, next_word_cnt;     // fill and write-back word index
    logic [SET_W-1:0] set_cnt, next_set_cnt;       // sweep and flush set index
    logic             flush_pend, next_flush_pend;
    logic             next_flush_done;
    logic             req_active;
    logic             word_done;
    logic             flush_dirty;

    // word address inside a block
    function automatic word_t block_addr(logic [TAG_W-1:0] tag, logic [SET_W-1:0] idx,
                                         logic [OFS_W-1:0] ofs);
        cache_addr_t a;
        a.tag      = tag;
        a.idx      = idx;
        a.ofs      = ofs;
        a.byte_ofs = 2'b00;
        return word_t'(a);
    endfunction

    assign req_active  = req.ren || req.wen;
    assign word_done   = !mem_rsp.busy && (word_cnt == LAST_WORD);
    assign flush_dirty = tag_rd.valid && tag_rd.dirty;

    // a pending flush holds off the processor
    assign in_lookup = (state == LOOKUP) && !flush && !flush_pend;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= SWEEP;
            word_cnt   <= '0;
            set_cnt    <= '0;
            flush_pend <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            state      <= next_state;
            word_cnt   <= next_word_cnt;
            set_cnt    <= next_set_cnt;
            flush_pend <= next_flush_pend;
            flush_done <= next_flush_done;   // one cycle after the last set
        end
    end

    always_comb begin
        next_state      = state;
        next_word_cnt   = word_cnt;
        next_set_cnt    = set_cnt;
        next_flush_pend = (flush_pend || flush) && (state != FLUSH);
        next_flush_done = 1'b0;
        tag_wen         = 1'b0;
        data_wen        = 1'b0;
        tag_wr          = '0;       // invalid, clean
        data_wr         = data_rd;
        set_idx         = lookup.addr.idx;
        mem_req         = '0;

        case (state)
            SWEEP: begin
                set_idx      = set_cnt;
                tag_wen      = 1'b1;
                next_set_cnt = set_cnt + 1'b1;
                if (set_cnt == LAST_SET) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (flush || flush_pend) begin
                    next_state    = FLUSH;
                    next_set_cnt  = '0;
                    next_word_cnt = '0;
                end else if (req_active && lookup.hit) begin
                    if (req.wen) begin   // write hit, line becomes dirty
                        data_wen     = 1'b1;
                        data_wr      = merged;
                        tag_wen      = 1'b1;
                        tag_wr.valid = 1'b1;
                        tag_wr.dirty = 1'b1;
                        tag_wr.tag   = lookup.addr.tag;
                    end
                end else if (req_active) begin
                    next_word_cnt = '0;
                    if (lookup.victim_valid && lookup.victim_dirty) begin
                        next_state = WRITE_BACK;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end
            WRITE_BACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = block_addr(tag_rd.tag, lookup.addr.idx, word_cnt);
                mem_req.wdata = data_rd[word_cnt];
                if (!mem_rsp.busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                end
                if (word_done) begin
                    tag_wen    = 1'b1;   // victim gone, line invalid until filled
                    next_state = FETCH;
                end
            end
            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = block_addr(lookup.addr.tag, lookup.addr.idx, word_cnt);
                if (!mem_rsp.busy) begin
                    data_wen          = 1'b1;
                    data_wr[word_cnt] = mem_rsp.rdata;
                    next_word_cnt     = word_cnt + 1'b1;
                end
                if (word_done) begin
                    tag_wen      = 1'b1;
                    tag_wr.valid = 1'b1;
                    tag_wr.tag   = lookup.addr.tag;
                    next_state   = LOOKUP;  // request served there as a hit
                end
            end
            FLUSH: begin
                set_idx = set_cnt;
                if (flush_dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = block_addr(tag_rd.tag, set_cnt, word_cnt);
                    mem_req.wdata = data_rd[word_cnt];
                    if (!mem_rsp.busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
                // clean lines cost a single cycle
                if (!flush_dirty || word_done) begin
                    tag_wen      = 1'b1;
                    next_set_cnt = set_cnt + 1'b1;
                    if (set_cnt == LAST_SET) begin
                        next_state      = LOOKUP;
                        next_flush_done = 1'b1;
                    end
                end
            end
            default: next_state = SWEEP;
        endcase
    end

endmodule

// ==== addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode import cache_cfg_pkg::*, bus_pkg::*; (
    input  proc_req_t req,
    input  line_tag_t tag_rd,
    output lookup_t   lookup
);

    cache_addr_t addr;

    assign addr = cache_addr_t'(req.addr);

    // tag_rd is the line at addr.idx during lookup, fetch and write-back
    assign lookup.addr = addr;

    // hit only on a valid line with a matching tag
    assign lookup.hit = tag_rd.valid && (tag_rd.tag == addr.tag);

    // state of the line that a miss would replace
    assign lookup.victim_valid = tag_rd.valid;
    assign lookup.victim_dirty = tag_rd.valid && tag_rd.dirty;

endmodule

// ==== cache_array.sv ====
`timescale 1ns/1ps

// one entry per set, read is combinational
module cache_array #(
    parameter int  DEPTH   = 16,
    parameter type entry_t = logic
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] idx,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    assign rdata = mem[idx];

    // clocked write into the indexed set
    always_ff @(posedge CLK) begin
        if (nRST && wen) begin  // no writes while held in reset
            mem[idx] <= wdata;
        end
    end

endmodule

// ==== bus_pkg.sv ====
package bus_pkg;

    import cache_cfg_pkg::*;

    // processor side, held until busy falls
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        word_t                 addr;
        word_t                 wdata;
        logic [WORD_W/8-1:0]   byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;   // valid while busy is low
    } proc_rsp_t;

    // memory side, whole words only
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

endpackage

// ==== cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // geometry of the direct-mapped cache
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = 16;
    localparam int OFS_W       = $clog2(BLOCK_WORDS);
    localparam int SET_W       = $clog2(N_SETS);
    localparam int TAG_W       = WORD_W - SET_W - OFS_W - 2;

    typedef logic [WORD_W-1:0] word_t;

    // byte address split, msb first
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] idx;
        logic [OFS_W-1:0] ofs;      // word within block
        logic [1:0]       byte_ofs;
    } cache_addr_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } line_tag_t;

    typedef word_t [BLOCK_WORDS-1:0] line_data_t;

    // decode result handed to execute and result stages
    typedef struct packed {
        logic        hit;
        logic        victim_dirty;  // valid and dirty
        logic        victim_valid;
        cache_addr_t addr;
    } lookup_t;

endpackage
